/* bench/pitch_taming_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module pitch_taming_chk (
	input logic        clock,
	input logic        reset,
	input logic        check_i,
	input logic [15:0] check_t0_i,
	input logic        done_o,
	input logic        taming_valid_o
);

	int unsigned fail_count = 0;
	logic        armed;
	logic        reset_q;
	logic [2:0]  remaining;
	int          t0;
	int          lat;

	function automatic int zone_at(input int t);
		int z;
		z = (t < 0) ? 0 : t / 40;
		return (z > 3) ? 3 : z;
	endfunction

	assign t0 = int'($signed(check_t0_i));
	assign lat = zone_at(t0 + 9) - zone_at((t0 < 50) ? 0 : t0 - 50) + 3;

	// Shadow of the consumer scan, counts down to the report cycle
	always_ff @(posedge clock) begin
		reset_q <= reset;
		if (reset) begin
			armed <= 1'b0;
		end else if (!armed) begin
			if (check_i) begin
				armed <= 1'b1;
				remaining <= 3'(lat);
			end
		end else begin
			remaining <= remaining - 3'd1;
			if (remaining == 3'd1) begin
				armed <= 1'b0;
			end
		end
	end

	done_pulse: assert property (@(posedge clock) disable iff (reset) done_o |=> !done_o)
		else begin
			$error("done_o high for more than one cycle");
			fail_count++;
		end

	valid_pulse: assert property (@(posedge clock) disable iff (reset)
		taming_valid_o |=> !taming_valid_o)
		else begin
			$error("taming_valid_o high for more than one cycle");
			fail_count++;
		end

	quiet_in_reset: assert property (@(posedge clock)
		reset && reset_q |-> !done_o && !taming_valid_o)
		else begin
			$error("pulse output high during reset");
			fail_count++;
		end

	valid_latency: assert property (@(posedge clock) disable iff (reset)
		taming_valid_o == (armed && remaining == 3'd1))
		else begin
			$error("taming_valid_o off its fixed latency");
			fail_count++;
		end

endmodule

`default_nettype wire

/* bench/pitch_taming_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pitch_taming_tb;

	logic        clock;
	logic        reset;
	logic        start_i;
	logic [15:0] t0_i;
	logic [15:0] gain_pit_i;
	logic        check_i;
	logic [15:0] check_t0_i;
	logic        done_o;
	logic        taming_o;
	logic        taming_valid_o;

	logic signed [31:0] hist [4];
	logic [31:0]        rng_state;
	int                 errors;
	int                 test_errors;
	int                 tests_run;
	int                 tests_failed;

	pitch_taming u_pitch_taming (.*);

	bind pitch_taming pitch_taming_chk u_pitch_taming_chk (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic longint clamp32(input longint v);
		longint r;
		r = v;
		if (v > 64'sd2147483647) begin
			r = 64'sd2147483647;
		end else if (v < -64'sd2147483648) begin
			r = -64'sd2147483648;
		end
		return r;
	endfunction

	function automatic logic signed [31:0] err_step(input logic signed [31:0] e,
			input logic signed [15:0] g);
		longint hi;
		longint lo;
		longint m;
		longint s;
		hi = longint'(e) >>> 16;
		lo = (longint'(e) >>> 1) - (hi <<< 15);
		m = clamp32(2 * hi * longint'(g) + 2 * ((lo * longint'(g)) >>> 15));
		s = clamp32(2 * m);
		return 32'(clamp32(s + 16384));
	endfunction

	function automatic int zone_for(input int t);
		int z;
		z = (t < 0) ? 0 : t / 40;
		return (z > 3) ? 3 : z;
	endfunction

	function automatic int unsigned next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return {16'd0, rng_state[30:15]};
	endfunction

	task automatic model_update(input int t0, input logic [15:0] g);
		logic signed [31:0] worst;
		logic signed [31:0] a;
		logic signed [31:0] b;
		worst = 32'sd1;
		if (t0 < 40) begin
			a = err_step(hist[0], $signed(g));
			b = err_step(a, $signed(g));
			worst = (a > worst) ? a : worst;
			worst = (b > worst) ? b : worst;
		end else begin
			for (int k = zone_for(t0 - 40); k <= zone_for(t0 - 1); k++) begin
				a = err_step(hist[k], $signed(g));
				worst = (a > worst) ? a : worst;
			end
		end
		hist[3] = hist[2];
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = worst;
	endtask

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int k = 0; k < 4; k++) begin
			hist[k] = 32'sh0000_4000;
		end
	endtask

	// A second start pulse lands two cycles in when extra_start is set
	task automatic run_update(input string name, input int t0, input logic [15:0] g,
			input bit extra_start);
		int cycles;
		@(posedge clock);
		#1;
		start_i = 1'b1;
		t0_i = 16'(t0);
		gain_pit_i = g;
		model_update(t0, g);
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (extra_start && cycles == 2) begin
				start_i = 1'b1;
				t0_i = 16'd30;
				gain_pit_i = 16'h7FFF;
			end else begin
				start_i = 1'b0;
			end
		end while (!done_o && cycles < 200);
		if (!done_o) begin
			$display("%s: timed out waiting for done_o", name);
			test_errors++;
		end
	endtask

	task automatic run_check(input string name, input int t0, output bit got);
		int cycles;
		int z1;
		int z2;
		logic signed [31:0] max_err;
		bit expected;
		z1 = zone_for((t0 < 50) ? 0 : t0 - 50);
		z2 = zone_for(t0 + 9);
		max_err = -32'sd1;
		for (int k = z1; k <= z2; k++) begin
			max_err = (hist[k] > max_err) ? hist[k] : max_err;
		end
		expected = max_err > 32'sd983040000;
		@(posedge clock);
		#1;
		check_i = 1'b1;
		check_t0_i = 16'(t0);
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			check_i = 1'b0;
			cycles++;
		end while (!taming_valid_o && cycles < 200);
		got = taming_o;
		if (!taming_valid_o) begin
			$display("%s: timed out waiting for taming_valid_o", name);
			test_errors++;
		end else begin
			assert (cycles == z2 - z1 + 3) else begin
				$display("Error %s latency: expected %0d, actual %0d", name, z2 - z1 + 3, cycles);
				test_errors++;
			end
			assert (taming_o == expected) else begin
				$display("Error %s lag %0d taming: expected %0d, actual %0d",
					name, t0, expected, taming_o);
				test_errors++;
			end
		end
	endtask

	// One check per zone pair of the history
	task automatic check_zones(input string name);
		bit got;
		run_check(name, 20, got);
		run_check(name, 60, got);
		run_check(name, 100, got);
		run_check(name, 140, got);
	endtask

	task automatic expect_quiet(input string name, input int cycles);
		int pulses;
		pulses = 0;
		repeat (cycles) begin
			@(posedge clock);
			#1;
			pulses += int'(done_o);
		end
		assert (pulses == 0) else begin
			$display("Error %s extra done pulses: expected 0, actual %0d", name, pulses);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("%s: passed", name);
		end else begin
			$display("%s: failed with %0d errors", name, test_errors);
			tests_failed++;
			errors += test_errors;
		end
		test_errors = 0;
		tests_run++;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		bit got;
		int count;
		start_i = 1'b0;
		t0_i = 16'd0;
		gain_pit_i = 16'd0;
		check_i = 1'b0;
		check_t0_i = 16'd0;
		rng_state = 32'd90;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		apply_reset();

		run_check("test1_reset", 60, got);
		finish_test("test1_reset");

		// Two chained steps on h0 per update, so entry 0 alone crosses the threshold
		got = 1'b0;
		count = 0;
		while (!got && count < 40) begin
			run_update("test2_short", 20 + int'(next_rand() % 20), 16'h7FFF, 1'b0);
			run_check("test2_short", 20, got);
			count++;
		end
		if (!got) begin
			$display("test2_short: taming never reported after %0d updates", count);
			test_errors++;
		end
		check_zones("test2_short");
		finish_test("test2_short");

		repeat (6) begin
			run_update("test3_zones", 40 + int'(next_rand() % 104),
				16'(next_rand() % 32768), 1'b0);
			check_zones("test3_zones");
		end
		finish_test("test3_zones");

		// Gain near 2.0 doubles the error on each update
		apply_reset();
		got = 1'b0;
		count = 0;
		while (!got && count < 40) begin
			run_update("test4_growth", 60, 16'h7FFF, 1'b0);
			run_check("test4_growth", 60, got);
			count++;
		end
		if (!got) begin
			$display("test4_growth: taming never reported after %0d updates", count);
			test_errors++;
		end
		finish_test("test4_growth");

		run_update("test5_busy", 100, 16'(next_rand() % 32768), 1'b1);
		expect_quiet("test5_busy", 30);
		check_zones("test5_busy");
		finish_test("test5_busy");

		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, u_pitch_taming.u_pitch_taming_chk.fail_count);
		if (errors == 0 && u_pitch_taming.u_pitch_taming_chk.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* common/g729_pkg.sv */
`default_nettype none

package g729_pkg;

	////////////////////////////////////////
	// Codec constants
	////////////////////////////////////////

	localparam int L_SUBFR   = 40;
	localparam int L_INTER10 = 10;
	localparam int PIT_MIN   = 20;
	localparam int PIT_MAX   = 143;
	localparam int ZONE_LAST = 3;

	localparam logic signed [31:0] EXC_ERR_INIT = 32'sh0000_4000;
	localparam logic signed [31:0] GAIN_ROUND   = 32'sh0000_4000;
	localparam logic signed [31:0] L_THRESH_ERR = 32'sd983040000;

	typedef enum logic [3:0] {
		UPD_IDLE,
		UPD_SHORT_RD,
		UPD_SHORT_E1,
		UPD_SHORT_E2,
		UPD_ZONE_RD,
		UPD_ZONE_EVAL,
		UPD_SHIFT_RD,
		UPD_SHIFT_WR,
		UPD_FINISH
	} upd_state_t;

	typedef enum logic [1:0] {
		TST_IDLE,
		TST_SCAN_RD,
		TST_SCAN_EVAL,
		TST_REPORT
	} tst_state_t;

	// Zone of a lag, one zone per subframe
	function automatic logic [1:0] zone_of(input logic signed [15:0] t);
		logic [1:0] zone;
		if (t < 0) begin
			zone = 2'd0;
		end else if (t >= L_SUBFR * ZONE_LAST) begin
			zone = 2'(ZONE_LAST);
		end else begin
			zone = 2'(t / L_SUBFR);
		end
		return zone;
	endfunction

endpackage

`default_nettype wire

/* exc_err/exc_err_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_err_mem (
	input  logic        clock,
	input  logic        reset,
	input  logic        wr_en_i,
	input  logic [1:0]  wr_addr_i,
	input  logic [31:0] wr_data_i,
	input  logic [1:0]  rd_addr_a_i,
	output logic [31:0] rd_data_a_o,
	input  logic [1:0]  rd_addr_b_i,
	output logic [31:0] rd_data_b_o
);

	logic [31:0] mem [4];

	// History entries start from the init error
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int k = 0; k < 4; k++) begin
				mem[k] <= g729_pkg::EXC_ERR_INIT;
			end
		end else if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// Registered reads, old data on a same-cycle write
	always_ff @(posedge clock) begin
		rd_data_a_o <= mem[rd_addr_a_i];
		rd_data_b_o <= mem[rd_addr_b_i];
	end

endmodule

`default_nettype wire

/* exc_err/exc_err_test.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_err_test (
	input  logic        clock,
	input  logic        reset,
	input  logic        check_i,
	input  logic [15:0] check_t0_i,
	output logic [1:0]  mem_rd_addr_o,
	input  logic [31:0] mem_rd_data_i,
	output logic        taming_o,
	output logic        taming_valid_o
);

	g729_pkg::tst_state_t state;

	logic [1:0]         zone1_q;
	logic [1:0]         rd_idx;
	logic signed [31:0] max_q;
	logic               taming_q;
	logic               over_thresh;
	logic signed [15:0] t0_s;
	logic [1:0]         zone1;
	logic [1:0]         zone2;

	assign t0_s = $signed(check_t0_i);
	assign zone1 = g729_pkg::zone_of(16'(t0_s - g729_pkg::L_INTER10 - g729_pkg::L_SUBFR));
	assign zone2 = g729_pkg::zone_of(16'(t0_s + g729_pkg::L_INTER10 - 1));

	assign mem_rd_addr_o = rd_idx;
	assign over_thresh = max_q > g729_pkg::L_THRESH_ERR;
	assign taming_valid_o = state == g729_pkg::TST_REPORT;
	assign taming_o = (state == g729_pkg::TST_REPORT) ? over_thresh : taming_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= g729_pkg::TST_IDLE;
			taming_q <= 1'b0;
		end else begin
			case (state)
				g729_pkg::TST_IDLE: begin
					if (check_i) begin
						state <= g729_pkg::TST_SCAN_RD;
					end
				end
				g729_pkg::TST_SCAN_RD: state <= g729_pkg::TST_SCAN_EVAL;
				g729_pkg::TST_SCAN_EVAL: begin
					// Data in hand belongs to the zone above rd_idx
					if (rd_idx + 2'd1 == zone1_q) begin
						state <= g729_pkg::TST_REPORT;
					end
				end
				g729_pkg::TST_REPORT: begin
					taming_q <= over_thresh;
					state <= g729_pkg::TST_IDLE;
				end
				default: state <= g729_pkg::TST_IDLE;
			endcase
		end
	end

	// One read per cycle, zone2 down to zone1
	always_ff @(posedge clock) begin
		case (state)
			g729_pkg::TST_IDLE: begin
				if (check_i) begin
					zone1_q <= zone1;
					rd_idx <= zone2;
					max_q <= -32'sd1;
				end
			end
			g729_pkg::TST_SCAN_RD: rd_idx <= rd_idx - 2'd1;
			g729_pkg::TST_SCAN_EVAL: begin
				rd_idx <= rd_idx - 2'd1;
				if ($signed(mem_rd_data_i) > max_q) begin
					max_q <= mem_rd_data_i;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* exc_err/exc_err_update.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_err_update (
	input  logic        clock,
	input  logic        reset,
	input  logic        start_i,
	input  logic [15:0] t0_i,
	input  logic [15:0] gain_pit_i,
	output logic        done_o,
	output logic        mem_wr_en_o,
	output logic [1:0]  mem_wr_addr_o,
	output logic [31:0] mem_wr_data_o,
	output logic [1:0]  mem_rd_addr_o,
	input  logic [31:0] mem_rd_data_i
);

	g729_pkg::upd_state_t state;

	logic [15:0]        gain_q;
	logic signed [31:0] worst_q;
	logic [31:0]        chain_q;
	logic [1:0]         zone_idx;
	logic [1:0]         zone_end;
	logic [1:0]         shift_idx;
	logic signed [15:0] t0_s;
	logic [31:0]        step_in;
	logic [31:0]        step_out;
	logic               step_wins;

	assign t0_s = $signed(t0_i);

	// Second short-lag step chains on the first result
	assign step_in = (state == g729_pkg::UPD_SHORT_E2) ? chain_q : mem_rd_data_i;
	assign step_wins = $signed(step_out) > worst_q;

	fix_gain_step u_fix_gain_step (
		.err_i  (step_in),
		.gain_i (gain_q),
		.err_o  (step_out)
	);

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= g729_pkg::UPD_IDLE;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				g729_pkg::UPD_IDLE: begin
					if (start_i) begin
						if (t0_s < g729_pkg::L_SUBFR) begin
							state <= g729_pkg::UPD_SHORT_RD;
						end else begin
							state <= g729_pkg::UPD_ZONE_RD;
						end
					end
				end
				g729_pkg::UPD_SHORT_RD: state <= g729_pkg::UPD_SHORT_E1;
				g729_pkg::UPD_SHORT_E1: state <= g729_pkg::UPD_SHORT_E2;
				g729_pkg::UPD_SHORT_E2: state <= g729_pkg::UPD_SHIFT_RD;
				g729_pkg::UPD_ZONE_RD:  state <= g729_pkg::UPD_ZONE_EVAL;
				g729_pkg::UPD_ZONE_EVAL: begin
					if (zone_idx == zone_end) begin
						state <= g729_pkg::UPD_SHIFT_RD;
					end else begin
						state <= g729_pkg::UPD_ZONE_RD;
					end
				end
				g729_pkg::UPD_SHIFT_RD: state <= g729_pkg::UPD_SHIFT_WR;
				g729_pkg::UPD_SHIFT_WR: begin
					if (shift_idx == 2'd1) begin
						state <= g729_pkg::UPD_FINISH;
					end else begin
						state <= g729_pkg::UPD_SHIFT_RD;
					end
				end
				g729_pkg::UPD_FINISH: begin
					state <= g729_pkg::UPD_IDLE;
					done_o <= 1'b1;
				end
				default: state <= g729_pkg::UPD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Worst error and loop indices
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		case (state)
			g729_pkg::UPD_IDLE: begin
				if (start_i) begin
					gain_q <= gain_pit_i;
					worst_q <= 32'sd1;
					zone_idx <= g729_pkg::zone_of(16'(t0_s - g729_pkg::L_SUBFR));
					zone_end <= g729_pkg::zone_of(t0_s - 16'sd1);
				end
			end
			g729_pkg::UPD_SHORT_E1: begin
				chain_q <= step_out;
				if (step_wins) begin
					worst_q <= step_out;
				end
			end
			g729_pkg::UPD_SHORT_E2: begin
				if (step_wins) begin
					worst_q <= step_out;
				end
				shift_idx <= 2'd3;
			end
			g729_pkg::UPD_ZONE_EVAL: begin
				if (step_wins) begin
					worst_q <= step_out;
				end
				zone_idx <= zone_idx + 2'd1;
				shift_idx <= 2'd3;
			end
			g729_pkg::UPD_SHIFT_WR: shift_idx <= shift_idx - 2'd1;
			default: begin
			end
		endcase
	end

	// Memory port A and write port
	always_comb begin
		mem_rd_addr_o = 2'd0;
		mem_wr_en_o = 1'b0;
		mem_wr_addr_o = 2'd0;
		mem_wr_data_o = worst_q;
		case (state)
			g729_pkg::UPD_ZONE_RD:  mem_rd_addr_o = zone_idx;
			g729_pkg::UPD_SHIFT_RD: mem_rd_addr_o = shift_idx - 2'd1;
			g729_pkg::UPD_SHIFT_WR: begin
				mem_wr_en_o = 1'b1;
				mem_wr_addr_o = shift_idx;
				mem_wr_data_o = mem_rd_data_i;
			end
			g729_pkg::UPD_FINISH: begin
				// Newest worst error lands in entry 0
				mem_wr_en_o = 1'b1;
				mem_wr_addr_o = 2'd0;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* pitch_taming.f */
common/g729_pkg.sv
rtl/fix_gain_step.sv
exc_err/exc_err_mem.sv
exc_err/exc_err_update.sv
exc_err/exc_err_test.sv
rtl/pitch_taming.sv
bench/pitch_taming_chk.sv
bench/pitch_taming_tb.sv

/* rtl/fix_gain_step.sv */
`timescale 1ns/1ps
`default_nettype none

module fix_gain_step (
	input  logic [31:0] err_i,
	input  logic [15:0] gain_i,
	output logic [31:0] err_o
);

	logic signed [15:0] hi;
	logic signed [15:0] lo;
	logic signed [15:0] gain;
	logic signed [31:0] err_half;
	logic signed [31:0] lo_full;
	logic signed [31:0] prod_hi;
	logic signed [31:0] prod_lo;
	logic signed [33:0] mult_sum;
	logic signed [31:0] mult_sat;
	logic signed [33:0] shift_val;
	logic signed [31:0] shift_sat;
	logic signed [33:0] round_sum;

	function automatic logic [31:0] sat32(input logic signed [33:0] v);
		logic [31:0] r;
		if (v > 34'sd2147483647) begin
			r = 32'h7FFF_FFFF;
		end else if (v < -34'sd2147483648) begin
			r = 32'h8000_0000;
		end else begin
			r = v[31:0];
		end
		return r;
	endfunction

	////////////////////////////////////////
	// Split into hi and lo halves
	////////////////////////////////////////

	assign hi = $signed(err_i[31:16]);
	assign gain = $signed(gain_i);
	assign err_half = $signed(err_i) >>> 1;
	assign lo_full = err_half - (32'(hi) <<< 15);
	// Always within 0..32767
	assign lo = lo_full[15:0];

	////////////////////////////////////////
	// 32x16 multiply, shift, round
	////////////////////////////////////////

	assign prod_hi = hi * gain;
	assign prod_lo = lo * gain;
	assign mult_sum = (34'(prod_hi) <<< 1) + (34'(prod_lo >>> 15) <<< 1);
	assign mult_sat = sat32(mult_sum);

	assign shift_val = 34'(mult_sat) <<< 1;
	assign shift_sat = sat32(shift_val);

	assign round_sum = 34'(shift_sat) + 34'(g729_pkg::GAIN_ROUND);
	assign err_o = sat32(round_sum);

endmodule

`default_nettype wire

/* rtl/pitch_taming.sv */
`timescale 1ns/1ps
`default_nettype none

module pitch_taming (
	input  logic        clock,
	input  logic        reset,
	input  logic        start_i,
	input  logic [15:0] t0_i,
	input  logic [15:0] gain_pit_i,
	input  logic        check_i,
	input  logic [15:0] check_t0_i,
	output logic        done_o,
	output logic        taming_o,
	output logic        taming_valid_o
);

	logic        wr_en;
	logic [1:0]  wr_addr;
	logic [31:0] wr_data;
	logic [1:0]  rd_addr_a;
	logic [31:0] rd_data_a;
	logic [1:0]  rd_addr_b;
	logic [31:0] rd_data_b;

	// Producer owns the write port and port A
	exc_err_update u_exc_err_update (
		.clock         (clock),
		.reset         (reset),
		.start_i       (start_i),
		.t0_i          (t0_i),
		.gain_pit_i    (gain_pit_i),
		.done_o        (done_o),
		.mem_wr_en_o   (wr_en),
		.mem_wr_addr_o (wr_addr),
		.mem_wr_data_o (wr_data),
		.mem_rd_addr_o (rd_addr_a),
		.mem_rd_data_i (rd_data_a)
	);

	exc_err_mem u_exc_err_mem (
		.clock       (clock),
		.reset       (reset),
		.wr_en_i     (wr_en),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.rd_addr_a_i (rd_addr_a),
		.rd_data_a_o (rd_data_a),
		.rd_addr_b_i (rd_addr_b),
		.rd_data_b_o (rd_data_b)
	);

	exc_err_test u_exc_err_test (
		.clock          (clock),
		.reset          (reset),
		.check_i        (check_i),
		.check_t0_i     (check_t0_i),
		.mem_rd_addr_o  (rd_addr_b),
		.mem_rd_data_i  (rd_data_b),
		.taming_o       (taming_o),
		.taming_valid_o (taming_valid_o)
	);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the pitch_taming testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f pitch_taming.f \
	--top-module pitch_taming_tb -o sim_pitch_taming || exit 1
out=$(./obj_dir/sim_pitch_taming +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "TEST OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
